//--- list.f
+incdir+include
hw/byte_link_pkg.sv
hw/link_fsm.sv
hw/frame_datapath.sv
hw/accum_alu.sv
hw/byte_link_top.sv
verif/up_link_agent.sv
verif/byte_link_tb.sv

//--- verif/byte_link_tb.sv
/*
 * Byte link engine testbench.
 * Runs command frames through the uP link agent, models the
 * accumulator and checks the link and host handshakes.
 */
`default_nettype none

`include "byte_link_cfg.svh"

module byte_link_tb
  import byte_link_pkg::*;
();
  timeunit 1ns;
  timeprecision 1ps;

  localparam int DONE_LIMIT = 2000;
  localparam int NUM_OPS    = 30;

  logic                  clk;
  logic                  reset;
  logic                  soft_reset;
  logic                  start;
  logic                  up_hs;
  logic                  done;
  logic                  up_dir;
  logic                  link_hs;
  logic                  agent_timeout;
  logic [7:0]            up_data_in;
  logic [7:0]            up_data_out;
  logic [`BL_WORD_W-1:0] model_acc;

  byte_link_top u_byte_link_top (
    .clk         (clk),
    .reset       (reset),
    .soft_reset  (soft_reset),
    .start       (start),
    .up_hs       (up_hs),
    .up_data_in  (up_data_in),
    .done        (done),
    .up_dir      (up_dir),
    .link_hs     (link_hs),
    .up_data_out (up_data_out)
  );

  up_link_agent u_up_link_agent (
    .clk         (clk),
    .reset       (reset),
    .up_dir      (up_dir),
    .link_hs     (link_hs),
    .up_data_out (up_data_out),
    .up_hs       (up_hs),
    .up_data_in  (up_data_in),
    .hs_timeout  (agent_timeout)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  task automatic fail_run(input string what);
    $display("%s", what);
    $display("ERRORS FOUND");
    $fatal(1, "Simulation stopped at the first error.");
  endtask

  task automatic report_mismatch(input string sig, input logic [31:0] got,
                                 input logic [31:0] exp);
    fail_run($sformatf("ERR t=%0t %s got=%h exp=%h", $time, sig, got, exp));
  endtask

  // ====================================================================
  // Handshake checks
  // ====================================================================

  assert property (@(posedge clk) disable iff (!reset)
    ($rose(link_hs) && !up_dir) |-> up_hs)
    else fail_run("link_hs rose on a read while up_hs was low");
  assert property (@(posedge clk) disable iff (!reset)
    ($rose(link_hs) && up_hs) |-> !up_dir)
    else fail_run("up_dir was high on a read handshake");
  // The uP answers a write by raising up_hs while link_hs is already high.
  assert property (@(posedge clk) disable iff (!reset)
    ($rose(up_hs) && link_hs) |-> up_dir)
    else fail_run("up_dir was low on a write handshake");
  assert property (@(posedge clk) disable iff (!reset)
    (link_hs && $past(link_hs)) |-> $stable(up_dir))
    else fail_run("up_dir changed during a handshake");
  assert property (@(posedge clk) disable iff (!reset)
    (up_dir && link_hs && $past(up_dir && link_hs)) |-> $stable(up_data_out))
    else fail_run("up_data_out changed while link_hs was high on a write");
  assert property (@(posedge clk) disable iff (!reset)
    (done && start && !soft_reset) |=> done)
    else fail_run("done fell while start was still held");
  assert property (@(posedge clk) disable iff (!reset)
    (done && $past(done) && !start) |=> !done)
    else fail_run("done stayed high after start dropped");
  assert property (@(posedge clk) disable iff (!reset)
    $rose(done) |-> (!up_hs && !link_hs))
    else fail_run("done rose before the last write handshake completed");
  assert property (@(posedge clk) !agent_timeout)
    else fail_run("uP agent timed out waiting on link_hs");

  // Accumulator model built from the opcode table.
  function automatic logic [`BL_WORD_W-1:0] model_op(input logic [`BL_WORD_W-1:0] acc,
                                                    input logic [7:0] op,
                                                    input logic [`BL_WORD_W-1:0] value);
    case (op)
      OP_LOAD: return value;
      OP_ADD:  return acc + value;
      OP_SUB:  return acc - value;
      OP_AND:  return acc & value;
      OP_OR:   return acc | value;
      OP_XOR:  return acc ^ value;
      default: return acc;
    endcase
  endfunction

  task automatic wait_for_done(input logic level);
    int cycles;
    cycles = 0;
    @(negedge clk);
    while (done !== level && cycles < DONE_LIMIT) begin
      @(negedge clk);
      cycles++;
    end
    assert (done === level)
      else fail_run($sformatf("timed out waiting for done to go %0b", level));
  endtask

  task automatic check_idle();
    @(negedge clk);
    assert (up_dir === 1'b0) else report_mismatch("up_dir", up_dir, 0);
    assert (link_hs === 1'b0) else report_mismatch("link_hs", link_hs, 0);
    assert (done === 1'b0) else report_mismatch("done", done, 0);
  endtask

  task automatic release_start();
    repeat ($urandom_range(4, 0)) @(posedge clk);
    @(posedge clk);
    start <= 1'b0;
    wait_for_done(1'b0);
  endtask

  task automatic send_frame(input logic [7:0] op, input logic [`BL_WORD_W-1:0] value);
    int i;
    u_up_link_agent.clear_rx();
    u_up_link_agent.queue_tx_byte(op);
    for (i = `BL_IN_BYTES - 2; i >= 0; i--) begin
      u_up_link_agent.queue_tx_byte(value[i*8 +: 8]);
    end
    model_acc = model_op(model_acc, op, value);
    @(posedge clk);
    start <= 1'b1;
    wait_for_done(1'b1);
    assert (u_up_link_agent.rx_count() == `BL_OUT_BYTES)
      else fail_run("result frame did not hold exactly four bytes at done");
    assert (u_up_link_agent.rx_word() == model_acc)
      else report_mismatch("up_data_out", u_up_link_agent.rx_word(), model_acc);
    release_start();
  endtask

  // Sends part of a frame, then aborts it with soft_reset.
  task automatic abort_frame();
    int cycles;
    cycles = 0;
    u_up_link_agent.queue_tx_byte(OP_ADD);
    u_up_link_agent.queue_tx_byte(8'h5a);
    @(posedge clk);
    start <= 1'b1;
    @(negedge clk);
    while (!u_up_link_agent.is_idle() && cycles < DONE_LIMIT) begin
      @(negedge clk);
      cycles++;
    end
    assert (u_up_link_agent.is_idle())
      else fail_run("uP agent did not finish the partial frame");
    @(posedge clk);
    start      <= 1'b0;
    soft_reset <= 1'b1;
    @(posedge clk);
    soft_reset <= 1'b0;
    model_acc = '0;
    repeat (3) check_idle();
  endtask

  // ====================================================================
  // Main sequence
  // ====================================================================

  initial begin
    int unsigned seed_draw;
    logic [7:0]  op;
    int          n;
    seed_draw = $urandom(43646);
    reset      <= 1'b0;
    soft_reset <= 1'b0;
    start      <= 1'b0;
    model_acc  = '0;
    repeat (16) @(posedge clk);
    reset <= 1'b1;
    repeat (4) check_idle();

    send_frame(OP_LOAD, $urandom());
    for (n = 0; n < NUM_OPS; n++) begin
      op = 8'($urandom_range(6, 1));
      send_frame(op, $urandom());
    end

    // Opcode bytes outside the table leave the accumulator alone.
    send_frame(8'($urandom_range(255, 7)), $urandom());
    send_frame(8'h00, $urandom());

    abort_frame();
    send_frame(OP_ADD, $urandom());
    check_idle();

    $display("NO ERRORS");
    $finish;
  end

endmodule

`default_nettype wire

//--- verif/up_link_agent.sv
/*
 * Behavioural uP side of the byte link.
 * Supplies command bytes and collects result bytes over the
 * four-phase handshake with random response delays.
 */
`default_nettype none

`include "byte_link_cfg.svh"

module up_link_agent (
  input  logic       clk,
  input  logic       reset,
  input  logic       up_dir,
  input  logic       link_hs,
  input  logic [7:0] up_data_out,
  output logic       up_hs,
  output logic [7:0] up_data_in,
  output logic       hs_timeout
);
  timeunit 1ns;
  timeprecision 1ps;

  localparam int HS_LIMIT = 200;

  logic [7:0] tx_queue[$];
  logic [7:0] rx_queue[$];
  logic       busy;

  function automatic void queue_tx_byte(input logic [7:0] value);
    tx_queue.push_back(value);
  endfunction

  function automatic void clear_rx();
    rx_queue.delete();
  endfunction

  function automatic int rx_count();
    return rx_queue.size();
  endfunction

  // Result bytes arrive most significant first.
  function automatic logic [`BL_WORD_W-1:0] rx_word();
    logic [`BL_WORD_W-1:0] word;
    word = '0;
    foreach (rx_queue[i]) begin
      word = {word[`BL_WORD_W-9:0], rx_queue[i]};
    end
    return word;
  endfunction

  function automatic logic is_idle();
    return (tx_queue.size() == 0) && !busy;
  endfunction

  task automatic random_delay();
    int unsigned cycles;
    cycles = $urandom_range(5, 0);
    repeat (cycles) @(posedge clk);
  endtask

  // Polls at falling edges, where link_hs has settled.
  task automatic wait_link_hs(input logic level);
    int cycles;
    cycles = 0;
    @(negedge clk);
    while (link_hs !== level && cycles < HS_LIMIT) begin
      @(negedge clk);
      cycles++;
    end
    if (link_hs !== level) begin
      hs_timeout = 1'b1;
    end
  endtask

  task automatic read_handshake();
    busy = 1'b1;
    random_delay();
    @(posedge clk);
    up_data_in <= tx_queue.pop_front();
    up_hs      <= 1'b1;
    wait_link_hs(1'b1);
    random_delay();
    @(posedge clk);
    up_hs <= 1'b0;
    wait_link_hs(1'b0);
    busy = 1'b0;
  endtask

  task automatic write_handshake();
    busy = 1'b1;
    rx_queue.push_back(up_data_out);
    random_delay();
    @(posedge clk);
    up_hs <= 1'b1;
    wait_link_hs(1'b0);
    random_delay();
    @(posedge clk);
    up_hs <= 1'b0;
    busy = 1'b0;
  endtask

  initial begin
    up_hs      <= 1'b0;
    up_data_in <= 8'h00;
    busy       = 1'b0;
    hs_timeout = 1'b0;
    forever begin
      @(negedge clk);
      if (reset && up_dir && link_hs) begin
        write_handshake();
      end else if (reset && !up_dir && !link_hs && tx_queue.size() > 0) begin
        read_handshake();
      end
    end
  end

endmodule

`default_nettype wire

//--- hw/byte_link_top.sv
/*
 * Byte link engine top level.
 * Control machine, frame datapath and accumulator behind a
 * host start/done pair and a four-phase uP byte link.
 */
`default_nettype none

`include "byte_link_cfg.svh"

module byte_link_top
  import byte_link_pkg::*;
(
  input  logic       clk,
  input  logic       reset,
  input  logic       soft_reset,
  input  logic       start,
  input  logic       up_hs,
  input  logic [7:0] up_data_in,
  output logic       done,
  output logic       up_dir,
  output logic       link_hs,
  output logic [7:0] up_data_out
);

  logic                  count_zero;
  logic                  capture_byte;
  logic                  set_in_count;
  logic                  set_out_count;
  logic                  decrement;
  logic                  exec;
  link_op_t              opcode;
  logic [`BL_WORD_W-1:0] operand;
  logic [`BL_WORD_W-1:0] result;

  link_fsm u_link_fsm (
    .clk           (clk),
    .reset         (reset),
    .soft_reset    (soft_reset),
    .start         (start),
    .up_hs         (up_hs),
    .count_zero    (count_zero),
    .up_dir        (up_dir),
    .link_hs       (link_hs),
    .done          (done),
    .capture_byte  (capture_byte),
    .set_in_count  (set_in_count),
    .set_out_count (set_out_count),
    .decrement     (decrement),
    .exec          (exec)
  );

  frame_datapath u_frame_datapath (
    .clk           (clk),
    .reset         (reset),
    .soft_reset    (soft_reset),
    .capture_byte  (capture_byte),
    .set_in_count  (set_in_count),
    .set_out_count (set_out_count),
    .decrement     (decrement),
    .up_data_in    (up_data_in),
    .result        (result),
    .count_zero    (count_zero),
    .up_data_out   (up_data_out),
    .opcode        (opcode),
    .operand       (operand)
  );

  accum_alu u_accum_alu (
    .clk        (clk),
    .reset      (reset),
    .soft_reset (soft_reset),
    .exec       (exec),
    .opcode     (opcode),
    .operand    (operand),
    .result     (result)
  );

endmodule

`default_nettype wire

//--- hw/accum_alu.sv
/*
 * Accumulator ALU.
 * Applies the frame opcode to the 32-bit accumulator on exec.
 */
`default_nettype none

`include "byte_link_cfg.svh"

module accum_alu
  import byte_link_pkg::*;
(
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  soft_reset,
  input  logic                  exec,
  input  link_op_t              opcode,
  input  logic [`BL_WORD_W-1:0] operand,
  output logic [`BL_WORD_W-1:0] result
);

  logic [`BL_WORD_W-1:0] accum;
  logic [`BL_WORD_W-1:0] accum_next;

  // Unknown opcodes leave the accumulator as it is.
  always_comb begin
    case (opcode)
      OP_LOAD: accum_next = operand;
      OP_ADD:  accum_next = accum + operand;
      OP_SUB:  accum_next = accum - operand;
      OP_AND:  accum_next = accum & operand;
      OP_OR:   accum_next = accum | operand;
      OP_XOR:  accum_next = accum ^ operand;
      default: accum_next = accum;
    endcase
  end

  always_ff @(posedge clk or negedge reset) begin
    if (!reset) begin
      accum <= '0;
    end else if (soft_reset) begin
      accum <= '0;
    end else if (exec) begin
      accum <= accum_next;
    end
  end

  // Valid from the cycle after exec.
  assign result = accum;

endmodule

`default_nettype wire

//--- hw/frame_datapath.sv
/*
 * Frame datapath.
 * Byte counter, command frame assembly and result serializer.
 */
`default_nettype none

`include "byte_link_cfg.svh"

module frame_datapath
  import byte_link_pkg::*;
(
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  soft_reset,
  input  logic                  capture_byte,
  input  logic                  set_in_count,
  input  logic                  set_out_count,
  input  logic                  decrement,
  input  logic [7:0]            up_data_in,
  input  logic [`BL_WORD_W-1:0] result,
  output logic                  count_zero,
  output logic [7:0]            up_data_out,
  output link_op_t              opcode,
  output logic [`BL_WORD_W-1:0] operand
);

  localparam int CMD_W = `BL_IN_BYTES * 8;
  localparam logic [`BL_CNT_W-1:0] IN_COUNT  = `BL_IN_BYTES;
  localparam logic [`BL_CNT_W-1:0] OUT_COUNT = `BL_OUT_BYTES;

  logic [`BL_CNT_W-1:0]  count;
  logic [CMD_W-1:0]      cmd_reg;
  logic [`BL_WORD_W-1:0] res_reg;

  // ====================================================================
  // Byte counter
  // ====================================================================

  always_ff @(posedge clk or negedge reset) begin
    if (!reset) begin
      count <= '0;
    end else if (soft_reset) begin
      count <= '0;
    end else if (set_in_count) begin
      count <= IN_COUNT;
    end else if (set_out_count) begin
      count <= OUT_COUNT;
    end else if (decrement) begin
      count <= count - 1'b1;
    end
  end

  assign count_zero = (count == '0);

  // ====================================================================
  // Command assembly and result serializer
  // ====================================================================

  // Bytes arrive most significant first, so each new byte enters at the bottom.
  always_ff @(posedge clk) begin
    if (soft_reset) begin
      cmd_reg <= '0;
    end else if (capture_byte) begin
      cmd_reg <= {cmd_reg[CMD_W-9:0], up_data_in};
    end
  end

  // The top byte is always the one on the link.
  always_ff @(posedge clk) begin
    if (soft_reset) begin
      res_reg <= '0;
    end else if (set_out_count) begin
      res_reg <= result;
    end else if (decrement) begin
      res_reg <= {res_reg[`BL_WORD_W-9:0], 8'h00};
    end
  end

  assign opcode      = link_op_t'(cmd_reg[CMD_W-1 -: 8]);
  assign operand     = cmd_reg[`BL_WORD_W-1:0];
  assign up_data_out = res_reg[`BL_WORD_W-1 -: 8];

endmodule

`default_nettype wire

//--- hw/link_fsm.sv
/*
 * Link control machine.
 * Moore FSM that reads a command frame from the uP one byte per
 * four-phase cycle, triggers the accumulator, writes the result
 * back and signals done to the host.
 */
`default_nettype none

module link_fsm
  import byte_link_pkg::*;
(
  input  logic clk,
  input  logic reset,
  input  logic soft_reset,
  input  logic start,
  input  logic up_hs,
  input  logic count_zero,
  output logic up_dir,
  output logic link_hs,
  output logic done,
  output logic capture_byte,
  output logic set_in_count,
  output logic set_out_count,
  output logic decrement,
  output logic exec
);

  link_state_t state, next_state;

  always_ff @(posedge clk or negedge reset) begin
    if (!reset) begin
      state <= S_IDLE;
    end else if (soft_reset) begin
      state <= S_IDLE;
    end else begin
      state <= next_state;
    end
  end

  // ====================================================================
  // Next state
  // ====================================================================

  always_comb begin
    next_state = state;
    case (state)
      S_IDLE:    next_state = start ? S_SET_IN : S_IDLE;
      S_SET_IN:  next_state = S_R0;

      // Read one byte from the uP.
      S_R0:      next_state = up_hs ? S_R1 : S_R0;
      S_R1:      next_state = S_R2;
      S_R2:      next_state = S_R3;
      S_R3:      next_state = up_hs ? S_R3 : S_RD_DEC;
      S_RD_DEC:  next_state = S_RD_CHK;
      S_RD_CHK:  next_state = count_zero ? S_E0 : S_R0;

      S_E0:      next_state = S_E1;
      S_E1:      next_state = S_SET_OUT;
      S_SET_OUT: next_state = S_W0;

      // Write one byte to the uP.
      S_W0:      next_state = S_W1;
      S_W1:      next_state = S_W2;
      S_W2:      next_state = up_hs ? S_W3 : S_W2;
      S_W3:      next_state = S_W4;
      S_W4:      next_state = up_hs ? S_W4 : S_WR_DEC;
      S_WR_DEC:  next_state = S_WR_CHK;
      S_WR_CHK:  next_state = count_zero ? S_DONE : S_W0;

      S_DONE:    next_state = S_HOLD;
      S_HOLD:    next_state = start ? S_HOLD : S_IDLE;
      default:   next_state = S_IDLE;
    endcase
  end

  // ====================================================================
  // Outputs
  // ====================================================================

  always_comb begin
    up_dir        = 1'b0;
    link_hs       = 1'b0;
    done          = 1'b0;
    capture_byte  = 1'b0;
    set_in_count  = 1'b0;
    set_out_count = 1'b0;
    decrement     = 1'b0;
    exec          = 1'b0;
    case (state)
      S_SET_IN:  set_in_count = 1'b1;
      S_R1:      capture_byte = 1'b1;
      S_R2, S_R3: begin
        link_hs = 1'b1;
      end
      S_RD_DEC:  decrement = 1'b1;
      S_E0:      exec = 1'b1;
      S_SET_OUT: set_out_count = 1'b1;
      S_W0, S_W3, S_W4, S_WR_CHK: begin
        up_dir = 1'b1;
      end
      S_W1, S_W2: begin
        up_dir  = 1'b1;
        link_hs = 1'b1;
      end
      S_WR_DEC: begin
        up_dir    = 1'b1;
        decrement = 1'b1;
      end
      S_DONE, S_HOLD: begin
        done = 1'b1;
      end
      default: begin
        up_dir = 1'b0;
      end
    endcase
  end

endmodule

`default_nettype wire

//--- hw/byte_link_pkg.sv
/*
 * Byte link package.
 * Control state and opcode types shared by the link engine.
 */
`default_nettype none

package byte_link_pkg;

  // Control states, grouped as setup, read, execute, write and completion.
  typedef enum logic [4:0] {
    S_IDLE, S_SET_IN,
    S_R0, S_R1, S_R2, S_R3,
    S_RD_DEC, S_RD_CHK,
    S_E0, S_E1,
    S_SET_OUT,
    S_W0, S_W1, S_W2, S_W3, S_W4,
    S_WR_DEC, S_WR_CHK,
    S_DONE, S_HOLD
  } link_state_t;

  // Opcodes carried in the first byte of a command frame.
  typedef enum logic [7:0] {
    OP_LOAD = 8'd1,
    OP_ADD  = 8'd2,
    OP_SUB  = 8'd3,
    OP_AND  = 8'd4,
    OP_OR   = 8'd5,
    OP_XOR  = 8'd6
  } link_op_t;

endpackage

`default_nettype wire

//--- include/byte_link_cfg.svh
/*
 * Byte link configuration.
 * Frame lengths in bytes, the accumulator word width and the width
 * of the frame byte counter.
 */
`ifndef BYTE_LINK_CFG_SVH
`define BYTE_LINK_CFG_SVH

// Command frame is one opcode byte followed by four operand bytes.
`define BL_IN_BYTES  5

// Result frame carries the accumulator, most significant byte first.
`define BL_OUT_BYTES 4

`define BL_WORD_W    32
`define BL_CNT_W     3

`endif
